//--- Bender.yml
package:
  name: response_arbiter

sources:
  # Design, in compile order
  - logic/resp_pkg.sv
  - logic/response_ingress.sv
  - logic/response_rr_arbiter.sv
  - logic/response_fifo.sv
  - logic/response_egress.sv
  - logic/response_arbiter_top.sv

  # Verification
  - target: test
    files:
      - test/response_arbiter_chk.sv
      - test/tb_response_arbiter.sv

//--- build.f
logic/resp_pkg.sv
logic/response_ingress.sv
logic/response_rr_arbiter.sv
logic/response_fifo.sv
logic/response_egress.sv
logic/response_arbiter_top.sv
test/response_arbiter_chk.sv
test/tb_response_arbiter.sv

//--- logic/resp_pkg.sv
/*
 * Response arbiter package
 * Command encoding, memory packet and FIFO flag structures, sizing constants
 */
`default_nettype none

package resp_pkg;

  // -------------------------------------------------------------------------
  // Sizing
  // -------------------------------------------------------------------------
  localparam int NUM_REQUESTORS   = 4;
  localparam int REQ_IDX_W        = $clog2(NUM_REQUESTORS);
  localparam int TAG_W            = 6;
  localparam int ADDR_W           = 32;
  localparam int DATA_W           = 32;
  localparam int FIFO_DEPTH       = 16;
  // prog_full rises at this occupancy
  localparam int FIFO_PROG_THRESH = 12;
  localparam int FIFO_PTR_W       = $clog2(FIFO_DEPTH);
  // One extra bit so a full FIFO is representable
  localparam int FIFO_CNT_W       = $clog2(FIFO_DEPTH + 1);

  // -------------------------------------------------------------------------
  // Packet types
  // -------------------------------------------------------------------------
  typedef enum logic [1:0] {
    CMD_MEM_READ     = 2'd0,
    CMD_MEM_WRITE    = 2'd1,
    CMD_MEM_RESPONSE = 2'd2,
    CMD_MEM_FLUSH    = 2'd3
  } mem_cmd_e;

  // 10 bits
  typedef struct packed {
    mem_cmd_e               cmd;
    logic [REQ_IDX_W-1:0]   src_id;
    logic [TAG_W-1:0]       tag;
  } memory_meta_t;

  // 74 bits
  typedef struct packed {
    memory_meta_t           meta;
    logic [ADDR_W-1:0]      addr;
    logic [DATA_W-1:0]      data;
  } memory_payload_t;

  typedef struct packed {
    logic                   valid;
    memory_payload_t        payload;
  } memory_packet_t;

  // -------------------------------------------------------------------------
  // FIFO control and flags
  // -------------------------------------------------------------------------
  typedef struct packed {
    logic rd_en;
  } fifo_ctrl_t;

  typedef struct packed {
    logic full;
    logic empty;
    logic valid;
    logic prog_full;
    logic setup_busy;
  } fifo_status_t;

endpackage

`default_nettype wire

//--- logic/response_arbiter_top.sv
/*
 * Response arbiter top
 * Merges four requestor response streams into one filtered, buffered stream
 */
`timescale 1ns/1ps
`default_nettype none

module response_arbiter_top (
  input  logic                                ap_clk,
  input  logic                                areset_control,
  input  resp_pkg::memory_packet_t            response_in [resp_pkg::NUM_REQUESTORS],
  input  logic [resp_pkg::NUM_REQUESTORS-1:0] arbiter_request,
  input  resp_pkg::fifo_ctrl_t                fifo_ctrl_in,
  output resp_pkg::fifo_status_t              fifo_status_out,
  output logic [resp_pkg::NUM_REQUESTORS-1:0] arbiter_grant,
  output resp_pkg::memory_packet_t            response_out,
  output logic                                fifo_setup
);

  // -------------------------------------------------------------------------
  // Internal buses
  // -------------------------------------------------------------------------
  // Ingress to arbiter
  resp_pkg::memory_packet_t            packets_reg [resp_pkg::NUM_REQUESTORS];
  logic [resp_pkg::NUM_REQUESTORS-1:0] request_reg;
  logic                                rd_en_reg;

  // Arbiter to FIFO
  resp_pkg::memory_packet_t            merged_packet;
  logic [resp_pkg::NUM_REQUESTORS-1:0] grant;

  // FIFO and egress
  resp_pkg::memory_payload_t           dout;
  resp_pkg::fifo_status_t              status;
  logic                                pop;

  // -------------------------------------------------------------------------
  // Pipeline
  // -------------------------------------------------------------------------
  response_ingress u_ingress (
    .ap_clk          (ap_clk),
    .areset_control  (areset_control),
    .response_in     (response_in),
    .arbiter_request (arbiter_request),
    .fifo_ctrl_in    (fifo_ctrl_in),
    .packets_reg     (packets_reg),
    .request_reg     (request_reg),
    .rd_en_reg       (rd_en_reg)
  );

  response_rr_arbiter u_arbiter (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .packets_reg    (packets_reg),
    .request_reg    (request_reg),
    .grant          (grant),
    .merged_packet  (merged_packet)
  );

  // Filter and buffer
  response_fifo u_fifo (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .merged_packet  (merged_packet),
    .pop            (pop),
    .dout           (dout),
    .status         (status)
  );

  response_egress u_egress (
    .ap_clk          (ap_clk),
    .areset_control  (areset_control),
    .rd_en_reg       (rd_en_reg),
    .dout            (dout),
    .status          (status),
    .grant           (grant),
    .pop             (pop),
    .response_out    (response_out),
    .fifo_status_out (fifo_status_out),
    .arbiter_grant   (arbiter_grant),
    .fifo_setup      (fifo_setup)
  );

endmodule

`default_nettype wire

//--- logic/response_egress.sv
/*
 * Response egress
 * Gates pops on not-empty and registers packet, flags, grant and setup level
 */
`timescale 1ns/1ps
`default_nettype none

module response_egress (
  input  logic                                ap_clk,
  input  logic                                areset_control,
  input  logic                                rd_en_reg,
  input  resp_pkg::memory_payload_t           dout,
  input  resp_pkg::fifo_status_t              status,
  input  logic [resp_pkg::NUM_REQUESTORS-1:0] grant,
  output logic                                pop,
  output resp_pkg::memory_packet_t            response_out,
  output resp_pkg::fifo_status_t              fifo_status_out,
  output logic [resp_pkg::NUM_REQUESTORS-1:0] arbiter_grant,
  output logic                                fifo_setup
);

  logic                      out_valid_q;
  resp_pkg::memory_payload_t out_payload_q;

  // The one place where empty guards a pop
  assign pop = rd_en_reg & ~status.empty;

  // -------------------------------------------------------------------------
  // Output registers
  // -------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      out_valid_q     <= 1'b0;
      // Reads empty and busy while in reset
      fifo_status_out <= '{full: 1'b0, empty: 1'b1, valid: 1'b0,
                           prog_full: 1'b0, setup_busy: 1'b1};
      arbiter_grant   <= '0;
      fifo_setup      <= 1'b1;
    end else begin
      out_valid_q     <= status.valid;
      fifo_status_out <= status;
      arbiter_grant   <= grant;
      // Stays high one more cycle via the FIFO flag
      fifo_setup      <= status.setup_busy;
    end
  end

  // Payload follows dout with no reset
  always_ff @(posedge ap_clk) begin
    out_payload_q <= dout;
  end

  assign response_out.valid   = out_valid_q;
  assign response_out.payload = out_payload_q;

endmodule

`default_nettype wire

//--- logic/response_fifo.sv
/*
 * Response FIFO
 * Keeps only memory responses and buffers them in a small synchronous FIFO
 */
`timescale 1ns/1ps
`default_nettype none

module response_fifo (
  input  logic                      ap_clk,
  input  logic                      areset_control,
  input  resp_pkg::memory_packet_t  merged_packet,
  input  logic                      pop,
  output resp_pkg::memory_payload_t dout,
  output resp_pkg::fifo_status_t    status
);

  // Filter register
  logic                      in_valid_q;
  resp_pkg::memory_payload_t in_payload_q;
  logic                      push;

  // Storage and bookkeeping
  resp_pkg::memory_payload_t       mem [resp_pkg::FIFO_DEPTH];
  logic [resp_pkg::FIFO_PTR_W-1:0] wr_ptr;
  logic [resp_pkg::FIFO_PTR_W-1:0] rd_ptr;
  logic [resp_pkg::FIFO_CNT_W-1:0] count;
  logic                            full;
  logic                            rd_valid_q;
  logic                            setup_q;

  // -------------------------------------------------------------------------
  // Command filter
  // -------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      in_valid_q <= 1'b0;
    end else begin
      in_valid_q <= merged_packet.valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    in_payload_q <= merged_packet.payload;
  end

  // Writes into a full FIFO are dropped
  assign full = (count == resp_pkg::FIFO_DEPTH);
  assign push = in_valid_q && !full &&
                (in_payload_q.meta.cmd == resp_pkg::CMD_MEM_RESPONSE);

  // -------------------------------------------------------------------------
  // Storage, registered read
  // -------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (push) begin
      mem[wr_ptr] <= in_payload_q;
    end
    if (pop) begin
      dout <= mem[rd_ptr];
    end
  end

  // Power-of-two depth, pointers wrap on their own
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      rd_valid_q <= 1'b0;
      setup_q    <= 1'b1;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // dout valid one cycle after the pop
      rd_valid_q <= pop;
      setup_q    <= 1'b0;
    end
  end

  // Flags straight from the counters
  always_comb begin
    status.full       = full;
    status.empty      = (count == '0);
    status.valid      = rd_valid_q;
    status.prog_full  = (count >= resp_pkg::FIFO_PROG_THRESH);
    status.setup_busy = setup_q;
  end

endmodule

`default_nettype wire

//--- logic/response_ingress.sv
/*
 * Response ingress
 * Registers requestor packets, request levels and the consumer pop level
 */
`timescale 1ns/1ps
`default_nettype none

module response_ingress (
  input  logic                                ap_clk,
  input  logic                                areset_control,
  input  resp_pkg::memory_packet_t            response_in [resp_pkg::NUM_REQUESTORS],
  input  logic [resp_pkg::NUM_REQUESTORS-1:0] arbiter_request,
  input  resp_pkg::fifo_ctrl_t                fifo_ctrl_in,
  output resp_pkg::memory_packet_t            packets_reg [resp_pkg::NUM_REQUESTORS],
  output logic [resp_pkg::NUM_REQUESTORS-1:0] request_reg,
  output logic                                rd_en_reg
);

  // Valid bits and payloads kept apart
  logic [resp_pkg::NUM_REQUESTORS-1:0] valid_q;
  resp_pkg::memory_payload_t           payload_q [resp_pkg::NUM_REQUESTORS];

  // -------------------------------------------------------------------------
  // Control flops
  // -------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      valid_q     <= '0;
      request_reg <= '0;
      rd_en_reg   <= 1'b0;
    end else begin
      for (int i = 0; i < resp_pkg::NUM_REQUESTORS; i++) begin
        valid_q[i] <= response_in[i].valid;
      end
      request_reg <= arbiter_request;
      // Consumer pop level, one cycle late
      rd_en_reg   <= fifo_ctrl_in.rd_en;
    end
  end

  // -------------------------------------------------------------------------
  // Payload flops
  // -------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    for (int i = 0; i < resp_pkg::NUM_REQUESTORS; i++) begin
      payload_q[i] <= response_in[i].payload;
    end
  end

  // Reassemble packets for the arbiter
  always_comb begin
    for (int i = 0; i < resp_pkg::NUM_REQUESTORS; i++) begin
      packets_reg[i].valid   = valid_q[i];
      packets_reg[i].payload = payload_q[i];
    end
  end

endmodule

`default_nettype wire

//--- logic/response_rr_arbiter.sv
/*
 * Round-robin response arbiter
 * One-hot grant from a rotating pointer, plus lowest-index merge of valid packets
 */
`timescale 1ns/1ps
`default_nettype none

module response_rr_arbiter (
  input  logic                                ap_clk,
  input  logic                                areset_control,
  input  resp_pkg::memory_packet_t            packets_reg [resp_pkg::NUM_REQUESTORS],
  input  logic [resp_pkg::NUM_REQUESTORS-1:0] request_reg,
  output logic [resp_pkg::NUM_REQUESTORS-1:0] grant,
  output resp_pkg::memory_packet_t            merged_packet
);

  // Rotating priority pointer
  logic [resp_pkg::REQ_IDX_W-1:0] ptr;
  logic [resp_pkg::REQ_IDX_W-1:0] idx;
  logic [resp_pkg::REQ_IDX_W-1:0] winner;
  logic                           found;

  // Merge path
  resp_pkg::memory_packet_t  merged_next;
  logic                      merged_valid_q;
  resp_pkg::memory_payload_t merged_payload_q;

  // -------------------------------------------------------------------------
  // Grant selection
  // -------------------------------------------------------------------------
  always_comb begin
    grant  = '0;
    winner = '0;
    found  = 1'b0;
    idx    = ptr;
    // Scan from the pointer upward, wrapping
    for (int off = 0; off < resp_pkg::NUM_REQUESTORS; off++) begin
      idx = ptr + off[resp_pkg::REQ_IDX_W-1:0];
      if (!found && request_reg[idx]) begin
        found  = 1'b1;
        winner = idx;
      end
    end
    if (found) begin
      grant[winner] = 1'b1;
    end
  end

  // Pointer moves one past the winner
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      ptr <= '0;
    end else if (found) begin
      ptr <= winner + 1'b1;
    end
  end

  // -------------------------------------------------------------------------
  // Packet merge
  // -------------------------------------------------------------------------
  always_comb begin
    merged_next       = packets_reg[0];
    merged_next.valid = 1'b0;
    // Downward scan so the lowest valid index wins
    for (int i = resp_pkg::NUM_REQUESTORS - 1; i >= 0; i--) begin
      if (packets_reg[i].valid) begin
        merged_next = packets_reg[i];
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      merged_valid_q <= 1'b0;
    end else begin
      merged_valid_q <= merged_next.valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    merged_payload_q <= merged_next.payload;
  end

  assign merged_packet.valid   = merged_valid_q;
  assign merged_packet.payload = merged_payload_q;

endmodule

`default_nettype wire

//--- test/response_arbiter_chk.sv
/*
 * Response arbiter checker
 * Concurrent assertions on reset state, grant legality and round-robin order
 */
`timescale 1ns/1ps
`default_nettype none

module response_arbiter_chk (
  input logic                                ap_clk,
  input logic                                areset_control,
  input logic [resp_pkg::NUM_REQUESTORS-1:0] arbiter_request,
  input logic [resp_pkg::NUM_REQUESTORS-1:0] arbiter_grant,
  input resp_pkg::memory_packet_t            response_out,
  input resp_pkg::fifo_status_t              fifo_status_out,
  input logic                                fifo_setup
);

  localparam int N = resp_pkg::NUM_REQUESTORS;

  // Failed assertions, read back by the testbench
  int         fail_count = 0;
  // Edges seen, saturating at 3
  logic [1:0] ticks = 2'd0;

  always @(posedge ap_clk) begin
    if (ticks != 2'd3) begin
      ticks <= ticks + 2'd1;
    end
  end

  // Next requestor in round-robin order
  function automatic logic [N-1:0] rotate_left(input logic [N-1:0] v);
    return {v[N-2:0], v[N-1]};
  endfunction

  // -------------------------------------------------------------------------
  // Reset state
  // -------------------------------------------------------------------------
  // During reset and on the cycle after it
  a_reset_state: assert property (@(posedge ap_clk)
    (ticks >= 2'd2 && ($past(areset_control) || $past(areset_control, 2)))
      |-> (arbiter_grant == '0 && !response_out.valid && fifo_status_out.empty))
    else begin
      $error("outputs not in reset state around reset");
      fail_count++;
    end

  a_setup_high: assert property (@(posedge ap_clk)
    (ticks >= 2'd2 && $past(areset_control)) |-> fifo_setup)
    else begin
      $error("fifo_setup low while in reset");
      fail_count++;
    end

  // Low from the second cycle after reset onward
  a_setup_low: assert property (@(posedge ap_clk)
    (ticks == 2'd3 && !areset_control && !$past(areset_control)
     && !$past(areset_control, 2)) |-> !fifo_setup)
    else begin
      $error("fifo_setup still high after reset");
      fail_count++;
    end

  // -------------------------------------------------------------------------
  // Grant rules
  // -------------------------------------------------------------------------
  a_grant_onehot: assert property (@(posedge ap_clk) disable iff (areset_control)
    $onehot0(arbiter_grant))
    else begin
      $error("arbiter_grant has more than one bit set");
      fail_count++;
    end

  // Grant only where a request stood two cycles earlier
  a_grant_requested: assert property (@(posedge ap_clk) disable iff (areset_control)
    (arbiter_grant & ~$past(arbiter_request, 2)) == '0)
    else begin
      $error("arbiter_grant without a matching request");
      fail_count++;
    end

  a_grant_follows: assert property (@(posedge ap_clk) disable iff (areset_control)
    $rose(&arbiter_request) |-> ##2 (arbiter_grant != '0))
    else begin
      $error("no grant two cycles after all requests rose");
      fail_count++;
    end

  // Full load, grants step one requestor per cycle
  a_grant_rotates: assert property (@(posedge ap_clk) disable iff (areset_control)
    ($past(&arbiter_request, 2) && $past(&arbiter_request, 3)
     && $past(arbiter_grant) != '0)
      |-> (arbiter_grant == rotate_left($past(arbiter_grant))))
    else begin
      $error("grant did not rotate under full load");
      fail_count++;
    end

endmodule

`default_nettype wire

//--- test/tb_response_arbiter.sv
/*
 * Response arbiter testbench
 * LFSR-driven requestor models feed the DUT and a scoreboard checks the merged stream
 */
`timescale 1ns/1ps
`default_nettype none

module tb_response_arbiter;

  localparam int N            = resp_pkg::NUM_REQUESTORS;
  localparam int RESET_CYCLES = 4;
  localparam int MIXED_PKTS   = 48;
  localparam int BUFFER_PKTS  = 13;
  // Cycle budgets per test
  localparam int LEN_RESET    = 12;
  localparam int LEN_FAIR     = 24;
  localparam int LEN_MIXED    = 400;
  localparam int LEN_BUFFER   = 160;
  localparam int CYCLE_LIMIT  = LEN_RESET + LEN_FAIR + LEN_MIXED + LEN_BUFFER + 200;

  logic                     ap_clk = 1'b0;
  logic                     areset_control;
  resp_pkg::memory_packet_t response_in [N];
  logic [N-1:0]             arbiter_request;
  resp_pkg::fifo_ctrl_t     fifo_ctrl_in;
  resp_pkg::fifo_status_t   fifo_status_out;
  logic [N-1:0]             arbiter_grant;
  resp_pkg::memory_packet_t response_out;
  logic                     fifo_setup;

  // Requestor queues and expected output stream
  resp_pkg::memory_packet_t req_q [N][$];
  resp_pkg::memory_packet_t exp_q [$];
  logic [31:0]              lfsr = 32'h9fec_4c4c;
  logic                     force_all = 1'b0;
  int                       cycle_count = 0;
  int                       out_count = 0;
  int                       error_count = 0;
  int                       tests_run = 0;
  int                       tests_failed = 0;

  always #20 ap_clk = ~ap_clk;

  response_arbiter_top UUT (
    .ap_clk          (ap_clk),
    .areset_control  (areset_control),
    .response_in     (response_in),
    .arbiter_request (arbiter_request),
    .fifo_ctrl_in    (fifo_ctrl_in),
    .fifo_status_out (fifo_status_out),
    .arbiter_grant   (arbiter_grant),
    .response_out    (response_out),
    .fifo_setup      (fifo_setup)
  );

  bind response_arbiter_top response_arbiter_chk u_chk (
    .ap_clk          (ap_clk),
    .areset_control  (areset_control),
    .arbiter_request (arbiter_request),
    .arbiter_grant   (arbiter_grant),
    .response_out    (response_out),
    .fifo_status_out (fifo_status_out),
    .fifo_setup      (fifo_setup)
  );

  // Run limit
  always @(posedge ap_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Verification failed");
      $finish;
    end
  end

  // -------------------------------------------------------------------------
  // Helpers
  // -------------------------------------------------------------------------
  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] lfsr_word(input int width);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < width; b++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  function automatic int total_errors();
    return error_count + UUT.u_chk.fail_count;
  endfunction

  function automatic logic queues_empty();
    for (int i = 0; i < N; i++) begin
      if (req_q[i].size() != 0) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic report_fail(input string msg);
    $display("[FAIL] %0t ns: %s", $time, msg);
    error_count++;
  endtask

  // Queue random packets at random requestors and count the memory responses
  task automatic add_packets(input int count, input logic resp_only, output int resp_count);
    resp_pkg::memory_packet_t pkt;
    logic [31:0]              word;
    logic [1:0]               src;
    resp_count = 0;
    for (int k = 0; k < count; k++) begin
      word = lfsr_word(2);
      src  = word[1:0];
      word = lfsr_word(2);
      pkt.valid               = 1'b1;
      pkt.payload.meta.cmd    = resp_only ? resp_pkg::CMD_MEM_RESPONSE
                                          : resp_pkg::mem_cmd_e'(word[1:0]);
      pkt.payload.meta.src_id = src;
      word = lfsr_word(6);
      pkt.payload.meta.tag    = word[5:0];
      pkt.payload.addr        = lfsr_word(32);
      pkt.payload.data        = lfsr_word(32);
      if (pkt.payload.meta.cmd == resp_pkg::CMD_MEM_RESPONSE) begin
        resp_count++;
      end
      req_q[src].push_back(pkt);
    end
  endtask

  // One clock of output check, grant response and request update
  task automatic step_cycle();
    resp_pkg::memory_packet_t head;
    @(posedge ap_clk);
    #1;
    if (response_out.valid) begin
      out_count++;
      assert (exp_q.size() != 0)
        else report_fail("response_out valid with no packet expected");
      if (exp_q.size() != 0) begin
        head = exp_q.pop_front();
        assert (response_out.payload == head.payload)
          else report_fail($sformatf("got src %0d tag %h data %h, expected src %0d tag %h data %h",
                                     response_out.payload.meta.src_id,
                                     response_out.payload.meta.tag, response_out.payload.data,
                                     head.payload.meta.src_id, head.payload.meta.tag,
                                     head.payload.data));
        assert (response_out.payload.meta.cmd == resp_pkg::CMD_MEM_RESPONSE)
          else report_fail("command other than memory response delivered");
      end
    end
    // Status valid and output valid both follow the FIFO read one cycle later
    assert (fifo_status_out.valid == response_out.valid)
      else report_fail("fifo_status_out.valid disagrees with response_out.valid");
    // Each grant pops one packet for a single cycle
    for (int i = 0; i < N; i++) begin
      response_in[i].valid = 1'b0;
      if (arbiter_grant[i] && req_q[i].size() != 0) begin
        response_in[i] = req_q[i].pop_front();
        if (response_in[i].payload.meta.cmd == resp_pkg::CMD_MEM_RESPONSE) begin
          exp_q.push_back(response_in[i]);
        end
      end
    end
    for (int i = 0; i < N; i++) begin
      arbiter_request[i] = force_all || (req_q[i].size() != 0 && lfsr_bit());
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    int errs;
    errs = total_errors() - errors_before;
    tests_run++;
    if (errs == 0) begin
      $display("PASS  %s", name);
    end else begin
      tests_failed++;
      $display("FAIL  %s  (%0d failed checks)", name, errs);
    end
  endtask

  // -------------------------------------------------------------------------
  // Test sequence
  // -------------------------------------------------------------------------
  initial begin
    int           errs_at;
    int           resp_count;
    int           out_at;
    logic [N-1:0] exp_grant;
    areset_control  = 1'b1;
    arbiter_request = '0;
    fifo_ctrl_in    = '0;
    for (int i = 0; i < N; i++) begin
      response_in[i] = '0;
    end

    // Idle outputs after reset
    errs_at = total_errors();
    repeat (RESET_CYCLES) step_cycle();
    areset_control = 1'b0;
    while (fifo_setup) step_cycle();
    step_cycle();
    assert (fifo_status_out.empty && !response_out.valid && arbiter_grant == '0
            && !fifo_status_out.full && !fifo_status_out.setup_busy)
      else report_fail("outputs not idle after reset");
    finish_test("reset", errs_at);

    // All four requesting with the pointer at 0
    errs_at   = total_errors();
    force_all = 1'b1;
    while (arbiter_grant == '0) step_cycle();
    for (int k = 0; k < 8; k++) begin
      exp_grant          = '0;
      exp_grant[k % N]   = 1'b1;
      assert (arbiter_grant == exp_grant)
        else report_fail($sformatf("grant %b, expected %b", arbiter_grant, exp_grant));
      step_cycle();
    end
    force_all = 1'b0;
    repeat (4) step_cycle();
    finish_test("fairness", errs_at);

    // Mixed commands with the consumer always reading
    errs_at            = total_errors();
    out_at             = out_count;
    fifo_ctrl_in.rd_en = 1'b1;
    add_packets(MIXED_PKTS, 1'b0, resp_count);
    while (!queues_empty() || exp_q.size() != 0) step_cycle();
    repeat (8) step_cycle();
    assert (out_count - out_at == resp_count)
      else report_fail($sformatf("%0d packets delivered, expected %0d",
                                 out_count - out_at, resp_count));
    finish_test("filtered_order", errs_at);

    // Fill past prog_full with the consumer stalled and then drain
    errs_at            = total_errors();
    out_at             = out_count;
    fifo_ctrl_in.rd_en = 1'b0;
    add_packets(BUFFER_PKTS, 1'b1, resp_count);
    while (!queues_empty()) step_cycle();
    repeat (8) step_cycle();
    assert (fifo_status_out.prog_full && !fifo_status_out.empty && !fifo_status_out.full
            && out_count == out_at)
      else report_fail("FIFO flags wrong or output seen while stalled");
    fifo_ctrl_in.rd_en = 1'b1;
    while (exp_q.size() != 0) step_cycle();
    while (!fifo_status_out.empty) step_cycle();
    assert (out_count - out_at == BUFFER_PKTS)
      else report_fail($sformatf("%0d packets drained, expected %0d",
                                 out_count - out_at, BUFFER_PKTS));
    finish_test("buffering", errs_at);

    $display("Summary: %0d tests, %0d failed, %0d testbench errors, %0d assertion errors",
             tests_run, tests_failed, error_count, UUT.u_chk.fail_count);
    if (tests_failed == 0 && total_errors() == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
